// File: l2_cache_pkg.sv
`default_nettype none

package l2_cache_pkg;

	// address geometry of the 16-bit processor address.
	localparam int addr_bits = 16;
	localparam int tag_bits = 8;
	localparam int index_bits = 4;
	localparam int offset_bits = 4;

	// associativity of every set.
	localparam int num_ways = 4;

	// the same address word, either as a flat word or split into its fields.
	// the offset is carried along but the cache never looks at it.
	typedef union packed
	{
		logic [addr_bits-1:0] word;
		struct packed
		{
			logic [tag_bits-1:0] tag;
			logic [index_bits-1:0] index;
			logic [offset_bits-1:0] offset;
		} fields;
	} l2_addr_t;

	// controller states.
	// check serves hits and decides on a miss.
	// write_back sends a dirty victim to memory.
	// fill loads the missing line into the victim way.
	typedef enum logic [1:0]
	{
		check = 2'd0,
		write_back = 2'd1,
		fill = 2'd2
	} l2_ctrl_state_t;

endpackage : l2_cache_pkg

`default_nettype wire

// File: l2_array.sv
`timescale 1ns/1ps
`default_nettype none

module l2_array
#(
	parameter int width = 1,
	parameter int num_sets = 16
)
(
	input logic clk,
	input logic arst_n,
	input logic write,
	input logic [l2_cache_pkg::index_bits-1:0] index,
	input logic [width-1:0] datain,
	output logic [width-1:0] dataout
);

	logic [width-1:0] entries [num_sets];

	// every entry is cleared so valid, dirty and lru start known.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < num_sets; i++)
				entries[i] <= '0;
		end
		else if (write)
		begin
			entries[index] <= datain;
		end
	end

	assign dataout = entries[index];

endmodule : l2_array

`default_nettype wire

// File: l2_cache_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_datapath
#(
	parameter int line_bits = 128
)
(
	input logic clk,
	input logic arst_n,
	input l2_cache_pkg::l2_addr_t mem_address,
	input logic [line_bits-1:0] cpu_data,
	input logic [line_bits-1:0] pmem_data,

	input logic [l2_cache_pkg::num_ways-1:0] valid_write,
	input logic [l2_cache_pkg::num_ways-1:0] dirty_write,
	input logic [l2_cache_pkg::num_ways-1:0] tag_write,
	input logic [l2_cache_pkg::num_ways-1:0] data_write,
	input logic valid_in,
	input logic dirty_in,
	input logic lru_write,
	input logic [2:0] lru_in,
	input logic fill_sel,
	input logic wb_addr_sel,

	output logic hit,
	output logic [1:0] hit_way,
	output logic [1:0] victim_way,
	output logic victim_dirty,
	output logic [2:0] lru_state,
	output logic [line_bits-1:0] data_out,
	output logic [line_bits-1:0] pdata_out,
	output l2_cache_pkg::l2_addr_t pmem_address
);

	import l2_cache_pkg::*;

	localparam int num_sets = 2 ** index_bits;

	logic [num_ways-1:0] valid_way;
	logic [num_ways-1:0] dirty_way;
	logic [num_ways-1:0] match_way;
	logic [tag_bits-1:0] tag_way [num_ways];
	logic [line_bits-1:0] data_way [num_ways];

	logic [line_bits-1:0] data_in;
	l2_addr_t wb_addr;

	// a fill takes the memory line, a write hit takes the upper-cache line.
	assign data_in = fill_sel ? pmem_data : cpu_data;

	for (genvar w = 0; w < num_ways; w++)
	begin : g_way
		l2_array #(.width(1), .num_sets(num_sets)) valid_array
		(
			.clk(clk),
			.arst_n(arst_n),
			.write(valid_write[w]),
			.index(mem_address.fields.index),
			.datain(valid_in),
			.dataout(valid_way[w])
		);

		l2_array #(.width(1), .num_sets(num_sets)) dirty_array
		(
			.clk(clk),
			.arst_n(arst_n),
			.write(dirty_write[w]),
			.index(mem_address.fields.index),
			.datain(dirty_in),
			.dataout(dirty_way[w])
		);

		l2_array #(.width(tag_bits), .num_sets(num_sets)) tag_array
		(
			.clk(clk),
			.arst_n(arst_n),
			.write(tag_write[w]),
			.index(mem_address.fields.index),
			.datain(mem_address.fields.tag),
			.dataout(tag_way[w])
		);

		l2_array #(.width(line_bits), .num_sets(num_sets)) data_array
		(
			.clk(clk),
			.arst_n(arst_n),
			.write(data_write[w]),
			.index(mem_address.fields.index),
			.datain(data_in),
			.dataout(data_way[w])
		);

		assign match_way[w] = valid_way[w] && (tag_way[w] == mem_address.fields.tag);
	end

	l2_array #(.width(3), .num_sets(num_sets)) lru_array
	(
		.clk(clk),
		.arst_n(arst_n),
		.write(lru_write),
		.index(mem_address.fields.index),
		.datain(lru_in),
		.dataout(lru_state)
	);

	assign hit = |match_way;

	// lowest matching way wins; searching downwards leaves it last.
	always_comb
	begin
		hit_way = 2'd0;
		for (int i = num_ways - 1; i >= 0; i--)
		begin
			if (match_way[i])
				hit_way = 2'(i);
		end
	end

	assign data_out = data_way[hit_way];

	// bit 0 picks the pair, bits 1 and 2 pick the way inside each pair.
	always_comb
	begin
		if (lru_state[0])
			victim_way = lru_state[2] ? 2'd3 : 2'd2;
		else
			victim_way = lru_state[1] ? 2'd1 : 2'd0;
	end

	assign victim_dirty = dirty_way[victim_way];
	assign pdata_out = data_way[victim_way];

	// the victim line lives at its own tag in the current set.
	always_comb
	begin
		wb_addr.fields.tag = tag_way[victim_way];
		wb_addr.fields.index = mem_address.fields.index;
		wb_addr.fields.offset = '0;
	end

	assign pmem_address = wb_addr_sel ? wb_addr : mem_address;

endmodule : l2_cache_datapath

`default_nettype wire

// File: l2_cache_control.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_control
(
	input logic clk,
	input logic arst_n,

	input logic mem_read,
	input logic mem_write,
	input logic hit,
	input logic [1:0] hit_way,
	input logic [1:0] victim_way,
	input logic victim_dirty,
	input logic [2:0] lru_state,
	input logic pmem_resp,

	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output logic [l2_cache_pkg::num_ways-1:0] valid_write,
	output logic [l2_cache_pkg::num_ways-1:0] dirty_write,
	output logic [l2_cache_pkg::num_ways-1:0] tag_write,
	output logic [l2_cache_pkg::num_ways-1:0] data_write,
	output logic valid_in,
	output logic dirty_in,
	output logic lru_write,
	output logic [2:0] lru_in,
	output logic fill_sel,
	output logic wb_addr_sel
);

	import l2_cache_pkg::*;

	l2_ctrl_state_t state;
	l2_ctrl_state_t state_next;

	logic request;
	logic [num_ways-1:0] hit_onehot;
	logic [num_ways-1:0] victim_onehot;

	function automatic logic [num_ways-1:0] way_onehot(input logic [1:0] way);
		logic [num_ways-1:0] strobe;
		strobe = '0;
		strobe[way] = 1'b1;
		return strobe;
	endfunction

	// the accessed way becomes most recent, so the tree points away from it.
	function automatic logic [2:0] lru_touch(input logic [1:0] way, input logic [2:0] lru);
		logic [2:0] updated;
		updated = lru;
		if (way[1])
		begin
			updated[0] = 1'b0;
			updated[2] = ~way[0];
		end
		else
		begin
			updated[0] = 1'b1;
			updated[1] = ~way[0];
		end
		return updated;
	endfunction

	assign request = mem_read | mem_write;
	assign hit_onehot = way_onehot(hit_way);
	assign victim_onehot = way_onehot(victim_way);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= check;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;

		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		valid_write = '0;
		dirty_write = '0;
		tag_write = '0;
		data_write = '0;
		valid_in = 1'b0;
		dirty_in = 1'b0;
		lru_write = 1'b0;
		lru_in = lru_touch(hit_way, lru_state);
		fill_sel = 1'b0;
		wb_addr_sel = 1'b0;

		case (state)
			check:
			begin
				if (request && hit)
				begin
					mem_resp = 1'b1;
					lru_write = 1'b1;
					if (mem_write)
					begin
						// a write replaces the whole line and marks it dirty.
						data_write = hit_onehot;
						dirty_write = hit_onehot;
						dirty_in = 1'b1;
					end
				end
				else if (request)
				begin
					state_next = victim_dirty ? write_back : fill;
				end
			end

			write_back:
			begin
				pmem_write = 1'b1;
				wb_addr_sel = 1'b1;
				if (pmem_resp)
					state_next = fill;
			end

			fill:
			begin
				pmem_read = 1'b1;
				fill_sel = 1'b1;
				if (pmem_resp)
				begin
					valid_write = victim_onehot;
					valid_in = 1'b1;
					dirty_write = victim_onehot;
					dirty_in = 1'b0;
					tag_write = victim_onehot;
					data_write = victim_onehot;
					// the retry in check now hits and updates the lru.
					state_next = check;
				end
			end

			default:
			begin
				state_next = check;
			end
		endcase
	end

endmodule : l2_cache_control

`default_nettype wire

// File: l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache
#(
	parameter int line_bits = 128
)
(
	input logic clk,
	input logic arst_n,

	// upper-cache side.
	input logic mem_read,
	input logic mem_write,
	input logic [l2_cache_pkg::addr_bits-1:0] mem_address,
	input logic [line_bits-1:0] mem_wdata,
	output logic mem_resp,
	output logic [line_bits-1:0] mem_rdata,

	// physical memory side.
	output logic pmem_read,
	output logic pmem_write,
	output logic [l2_cache_pkg::addr_bits-1:0] pmem_address,
	output logic [line_bits-1:0] pmem_wdata,
	input logic [line_bits-1:0] pmem_rdata,
	input logic pmem_resp
);

	import l2_cache_pkg::*;

	l2_addr_t req_addr;
	l2_addr_t mem_addr_out;

	logic hit;
	logic [1:0] hit_way;
	logic [1:0] victim_way;
	logic victim_dirty;
	logic [2:0] lru_state;

	logic [num_ways-1:0] valid_write;
	logic [num_ways-1:0] dirty_write;
	logic [num_ways-1:0] tag_write;
	logic [num_ways-1:0] data_write;
	logic valid_in;
	logic dirty_in;
	logic lru_write;
	logic [2:0] lru_in;
	logic fill_sel;
	logic wb_addr_sel;

	assign req_addr.word = mem_address;
	assign pmem_address = mem_addr_out.word;

	l2_cache_control control
	(
		.clk(clk),
		.arst_n(arst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.lru_state(lru_state),
		.pmem_resp(pmem_resp),
		.mem_resp(mem_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.valid_write(valid_write),
		.dirty_write(dirty_write),
		.tag_write(tag_write),
		.data_write(data_write),
		.valid_in(valid_in),
		.dirty_in(dirty_in),
		.lru_write(lru_write),
		.lru_in(lru_in),
		.fill_sel(fill_sel),
		.wb_addr_sel(wb_addr_sel)
	);

	l2_cache_datapath #(.line_bits(line_bits)) datapath
	(
		.clk(clk),
		.arst_n(arst_n),
		.mem_address(req_addr),
		.cpu_data(mem_wdata),
		.pmem_data(pmem_rdata),
		.valid_write(valid_write),
		.dirty_write(dirty_write),
		.tag_write(tag_write),
		.data_write(data_write),
		.valid_in(valid_in),
		.dirty_in(dirty_in),
		.lru_write(lru_write),
		.lru_in(lru_in),
		.fill_sel(fill_sel),
		.wb_addr_sel(wb_addr_sel),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.lru_state(lru_state),
		.data_out(mem_rdata),
		.pdata_out(pmem_wdata),
		.pmem_address(mem_addr_out)
	);

endmodule : l2_cache

`default_nettype wire

// File: tb_l2_pmem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l2_pmem
#(
	parameter int line_bits = 128
)
(
	input logic clk,
	input logic arst_n,
	input logic pmem_read,
	input logic pmem_write,
	input logic [15:0] pmem_address,
	input logic [line_bits-1:0] pmem_wdata,
	output logic [line_bits-1:0] pmem_rdata,
	output logic pmem_resp,
	output int read_count,
	output int write_count,
	output logic [15:0] last_rd_addr,
	output logic [15:0] last_wb_addr,
	output logic [line_bits-1:0] last_wb_data
);

	logic [line_bits-1:0] lines [4096];
	logic busy;
	int wait_cnt;

	// each line starts out holding its own line address, repeated.
	initial
	begin
		for (int i = 0; i < 4096; i++)
			lines[i] = {(line_bits/16){16'(i << 4)}};
	end

	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pmem_resp <= 1'b0;
			pmem_rdata <= '0;
			busy <= 1'b0;
			wait_cnt <= 0;
			read_count <= 0;
			write_count <= 0;
			last_rd_addr <= '0;
			last_wb_addr <= '0;
			last_wb_data <= '0;
		end
		else
		begin
			pmem_resp <= 1'b0;
			if (pmem_resp)
				busy <= 1'b0;
			else if (!busy && (pmem_read || pmem_write))
			begin
				// the response comes one to four cycles after the request is seen.
				busy <= 1'b1;
				wait_cnt <= 1 + int'($urandom % 4);
			end
			else if (busy && wait_cnt > 1)
				wait_cnt <= wait_cnt - 1;
			else if (busy)
			begin
				pmem_resp <= 1'b1;
				if (pmem_write)
				begin
					lines[pmem_address[15:4]] <= pmem_wdata;
					write_count <= write_count + 1;
					last_wb_addr <= pmem_address;
					last_wb_data <= pmem_wdata;
				end
				else
				begin
					pmem_rdata <= lines[pmem_address[15:4]];
					read_count <= read_count + 1;
					last_rd_addr <= pmem_address;
				end
			end
		end
	end

endmodule : tb_l2_pmem

`default_nettype wire

// File: tb_l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache;

	import l2_cache_pkg::*;

	localparam int line_bits = 128;
	localparam int reps = line_bits / 16;
	localparam int num_steps = 28;
	localparam int miss_cycles = 12;
	localparam int timeout_cycles = num_steps * miss_cycles + 200;
	localparam logic rd = 1'b0;
	localparam logic wr = 1'b1;

	typedef struct packed
	{
		logic is_write;
		logic [15:0] addr;
		logic [15:0] seed;
		logic expect_hit;
		logic expect_wb;
		logic [15:0] wb_addr;
	} step_t;

	logic clk;
	logic arst_n;
	logic mem_read;
	logic mem_write;
	logic [15:0] mem_address;
	logic [line_bits-1:0] mem_wdata;
	logic mem_resp;
	logic [line_bits-1:0] mem_rdata;
	logic pmem_read;
	logic pmem_write;
	logic [15:0] pmem_address;
	logic [line_bits-1:0] pmem_wdata;
	logic [line_bits-1:0] pmem_rdata;
	logic pmem_resp;
	int read_count;
	int write_count;
	logic [15:0] last_rd_addr;
	logic [15:0] last_wb_addr;
	logic [line_bits-1:0] last_wb_data;

	step_t steps [num_steps];
	logic [line_bits-1:0] ref_lines [logic [15:0]];
	l2_ctrl_state_t ctrl_state;

	assign ctrl_state = dut.control.state;

	l2_cache #(.line_bits(line_bits)) dut
	(
		.clk(clk),
		.arst_n(arst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.mem_resp(mem_resp),
		.mem_rdata(mem_rdata),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp)
	);

	tb_l2_pmem #(.line_bits(line_bits)) memory
	(
		.clk(clk),
		.arst_n(arst_n),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp),
		.read_count(read_count),
		.write_count(write_count),
		.last_rd_addr(last_rd_addr),
		.last_wb_addr(last_wb_addr),
		.last_wb_data(last_wb_data)
	);

	initial
		clk = 1'b0;

	always #2 clk = ~clk;

	// columns are op, address, write seed, expect first-cycle hit, expect write-back, its address.
	// set 1 covers hits and allocation, set 3 walks the pseudo-LRU victim order.
	task automatic load_steps();
		steps[0] = '{rd, 16'h1210, 16'h0000, 1'b0, 1'b0, 16'h0000};
		steps[1] = '{rd, 16'h1218, 16'h0000, 1'b1, 1'b0, 16'h0000};
		steps[2] = '{wr, 16'h1214, 16'ha001, 1'b1, 1'b0, 16'h0000};
		steps[3] = '{rd, 16'h1210, 16'h0000, 1'b1, 1'b0, 16'h0000};
		steps[4] = '{wr, 16'h3410, 16'hb002, 1'b0, 1'b0, 16'h0000};
		steps[5] = '{rd, 16'h3410, 16'h0000, 1'b1, 1'b0, 16'h0000};
		steps[6] = '{wr, 16'h0130, 16'hc001, 1'b0, 1'b0, 16'h0000};
		steps[7] = '{rd, 16'h0230, 16'h0000, 1'b0, 1'b0, 16'h0000};
		steps[8] = '{wr, 16'h0330, 16'hc003, 1'b0, 1'b0, 16'h0000};
		steps[9] = '{rd, 16'h0430, 16'h0000, 1'b0, 1'b0, 16'h0000};
		steps[10] = '{rd, 16'h0530, 16'h0000, 1'b0, 1'b1, 16'h0130};
		steps[11] = '{rd, 16'h0630, 16'h0000, 1'b0, 1'b0, 16'h0000};
		steps[12] = '{rd, 16'h0730, 16'h0000, 1'b0, 1'b1, 16'h0330};
		steps[13] = '{rd, 16'h0130, 16'h0000, 1'b0, 1'b0, 16'h0000};
		steps[14] = '{wr, 16'h0630, 16'hc006, 1'b1, 1'b0, 16'h0000};
		steps[15] = '{wr, 16'h0530, 16'hc005, 1'b1, 1'b0, 16'h0000};
		steps[16] = '{rd, 16'h0830, 16'h0000, 1'b0, 1'b0, 16'h0000};
		steps[17] = '{rd, 16'h0930, 16'h0000, 1'b0, 1'b0, 16'h0000};
		steps[18] = '{rd, 16'h0a30, 16'h0000, 1'b0, 1'b1, 16'h0630};
		steps[19] = '{rd, 16'h0b30, 16'h0000, 1'b0, 1'b1, 16'h0530};
		steps[20] = '{rd, 16'h0630, 16'h0000, 1'b0, 1'b0, 16'h0000};
		steps[21] = '{rd, 16'h0530, 16'h0000, 1'b0, 1'b0, 16'h0000};
		steps[22] = '{rd, 16'h0b30, 16'h0000, 1'b1, 1'b0, 16'h0000};
		steps[23] = '{wr, 16'h5610, 16'hd001, 1'b0, 1'b0, 16'h0000};
		steps[24] = '{wr, 16'h7810, 16'hd002, 1'b0, 1'b0, 16'h0000};
		steps[25] = '{wr, 16'h9a10, 16'hd003, 1'b0, 1'b1, 16'h1210};
		steps[26] = '{rd, 16'h1210, 16'h0000, 1'b0, 1'b1, 16'h3410};
		steps[27] = '{rd, 16'h9a10, 16'h0000, 1'b1, 1'b0, 16'h0000};
	endtask

	// a line never written holds its line address, as the memory was loaded.
	function automatic logic [line_bits-1:0] expected_line(input logic [15:0] line_addr);
		if (ref_lines.exists(line_addr))
			return ref_lines[line_addr];
		else
			return {reps{line_addr}};
	endfunction

	task automatic compare(input logic [line_bits-1:0] actual,
		input logic [line_bits-1:0] expected, input string what);
		if (actual !== expected)
		begin
			$display("Fail at %0d ns: %s: got %h, expected %h", $time, what, actual, expected);
			$display("TB FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic run_step(input int n);
		step_t s;
		logic [15:0] line_addr;
		int cycles;
		int reads_before;
		int writes_before;
		s = steps[n];
		line_addr = s.addr & 16'hfff0;
		reads_before = read_count;
		writes_before = write_count;
		cycles = 0;
		@(posedge clk);
		mem_read <= ~s.is_write;
		mem_write <= s.is_write;
		mem_address <= s.addr;
		mem_wdata <= {reps{s.seed}};
		@(negedge clk);
		while (!mem_resp)
		begin
			cycles++;
			@(negedge clk);
		end
		compare(line_bits'(cycles == 0), line_bits'(s.expect_hit),
			$sformatf("step %0d response in the first cycle", n));
		if (s.expect_hit)
			compare(line_bits'(read_count), line_bits'(reads_before),
				$sformatf("step %0d memory reads on a hit", n));
		else
		begin
			compare(line_bits'(read_count), line_bits'(reads_before + 1),
				$sformatf("step %0d memory reads on a miss", n));
			compare(line_bits'(last_rd_addr & 16'hfff0), line_bits'(line_addr),
				$sformatf("step %0d fill address", n));
		end
		compare(line_bits'(write_count), line_bits'(writes_before + (s.expect_wb ? 1 : 0)),
			$sformatf("step %0d memory write-backs", n));
		if (s.expect_wb)
		begin
			compare(line_bits'(last_wb_addr), line_bits'(s.wb_addr),
				$sformatf("step %0d write-back address", n));
			compare(last_wb_data, expected_line(s.wb_addr),
				$sformatf("step %0d write-back data", n));
		end
		if (s.is_write)
			ref_lines[line_addr] = {reps{s.seed}};
		else
			compare(mem_rdata, expected_line(line_addr),
				$sformatf("step %0d read data of line %h", n, line_addr));
	endtask

	initial
	begin
		void'($urandom(89181));
		mem_read <= 1'b0;
		mem_write <= 1'b0;
		mem_address <= '0;
		mem_wdata <= '0;
		arst_n <= 1'b0;
		load_steps();
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		for (int n = 0; n < num_steps; n++)
			run_step(n);
		@(posedge clk);
		mem_read <= 1'b0;
		mem_write <= 1'b0;
		@(posedge clk);
		$display("TB PASSED");
		$finish;
	end

	// the worst miss takes about a dozen cycles, so this bounds the whole table.
	initial
	begin
		repeat (timeout_cycles) @(posedge clk);
		$display("The run timed out after %0d clock cycles with the controller in state %s.",
			timeout_cycles, ctrl_state.name());
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule : tb_l2_cache

`default_nettype wire

// File: l2_cache.f
l2_cache_pkg.sv
l2_array.sv
l2_cache_datapath.sv
l2_cache_control.sv
l2_cache.sv
tb_l2_pmem.sv
tb_l2_cache.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP ?= tb_l2_cache
RTL_TOP ?= l2_cache
FILELIST ?= l2_cache.f
BUILD_DIR ?= obj_dir
PASS_MSG := TB PASSED
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
